// ==== list.f ====
+incdir+.
rb_pkg.sv
rb_byte_feeder.sv
rb_rabin.sv
rb_chunker.sv
rb_top.sv
tb_clock.sv
rb_tb.sv

// ==== rb_byte_feeder.sv ====
// Input side: pops 64-bit words from a show-ahead FIFO, issues bytes LSB first
// Jobs are whole words; a new job starts on a rising start_i while idle
`timescale 1ns/1ps

module rb_byte_feeder (
   input  logic             wb_clk_i,
   input  logic             wb_rst_i,
   input  logic             start_i,
   input  logic [63:0]      src_data_i,
   input  logic             src_last_i,
   input  logic             src_empty_i,
   input  logic             dst_almost_full_i,
   input  logic             job_end_i,
   output logic             src_get_o,
   output logic             byte_valid_o,
   output rb_pkg::rb_byte_t byte_o,
   output logic             job_start_o,
   output logic             busy_o
);

   rb_pkg::rb_feed_state_e state_q;
   logic                   start_q;
   logic [63:0]            word_q;
   logic [2:0]             idx_q;
   logic                   last_q;
   logic                   start_rise;
   logic                   issue;

   assign start_rise = start_i && !start_q;

   // Back-pressure holds bytes in the word register, nothing downstream stalls
   assign issue = (state_q == rb_pkg::SHIFT) && !dst_almost_full_i;

   assign byte_valid_o = issue;
   assign byte_o.data  = word_q[{idx_q, 3'b000} +: 8];
   assign byte_o.last  = last_q && (idx_q == 3'd7);

   assign busy_o = (state_q != rb_pkg::IDLE);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q     <= rb_pkg::IDLE;
         start_q     <= 1'b0;
         idx_q       <= 3'd0;
         src_get_o   <= 1'b0;
         job_start_o <= 1'b0;
      end else begin
         start_q     <= start_i;
         src_get_o   <= 1'b0;
         job_start_o <= 1'b0;
         case (state_q)
            rb_pkg::IDLE: begin
               if (start_rise) begin
                  job_start_o <= 1'b1;
                  state_q     <= rb_pkg::LOAD;
               end
            end
            rb_pkg::LOAD: begin
               // Word captured now, popped on the next cycle
               if (!src_empty_i) begin
                  src_get_o <= 1'b1;
                  idx_q     <= 3'd0;
                  state_q   <= rb_pkg::SHIFT;
               end
            end
            rb_pkg::SHIFT: begin
               if (issue) begin
                  idx_q <= idx_q + 3'd1;
                  if (idx_q == 3'd7) begin
                     state_q <= last_q ? rb_pkg::DONE : rb_pkg::LOAD;
                  end
               end
            end
            rb_pkg::DONE: begin
               // Hold until the chunker has written the last record
               if (job_end_i) begin
                  state_q <= rb_pkg::IDLE;
               end
            end
            default: begin
               state_q <= rb_pkg::IDLE;
            end
         endcase
      end
   end

   // Current word and its last flag
   always_ff @(posedge wb_clk_i) begin
      if (state_q == rb_pkg::LOAD && !src_empty_i) begin
         word_q <= src_data_i;
         last_q <= src_last_i;
      end
   end

   // The pop strobe is registered, so the FIFO level seen a cycle earlier must still hold
   a_no_pop_on_empty: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(src_get_o) |-> !src_empty_i
   );

endmodule

// ==== rb_chunker.sv ====
// Output side: counts chunk bytes, decides cuts and writes one record per chunk
// Assumes the destination FIFO absorbs 2 records after almost-full rises
`timescale 1ns/1ps
`include "rb_config.svh"

module rb_chunker (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  logic               job_start_i,
   input  logic               hash_valid_i,
   input  rb_pkg::rb_hash_t   hash_i,
   output logic               dst_put_o,
   output rb_pkg::rb_record_t dst_data_o,
   output logic               job_end_o,
   output logic               done_o
);

   localparam logic [`RB_LEN_W-1:0]      MIN_LEN = `RB_MIN_CHUNK;
   localparam logic [`RB_LEN_W-1:0]      MAX_LEN = `RB_MAX_CHUNK;
   localparam logic [`RB_MAGIC_BITS-1:0] MAGIC   = `RB_MAGIC;

   // Bytes of the current chunk seen before this one
   logic [`RB_LEN_W-1:0] cnt_q;
   logic [`RB_LEN_W-1:0] cnt_next;
   logic                 hit_max;
   logic                 hit_magic;
   logic                 cut;

   // Count including the current byte
   assign cnt_next = cnt_q + 1'b1;

   assign hit_max   = (cnt_next == MAX_LEN);
   assign hit_magic = (cnt_next >= MIN_LEN) &&
                      (hash_i.hash[`RB_MAGIC_BITS-1:0] == MAGIC);
   assign cut       = hit_max || hit_magic || hash_i.last;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cnt_q     <= '0;
         dst_put_o <= 1'b0;
         job_end_o <= 1'b0;
         done_o    <= 1'b0;
      end else begin
         dst_put_o <= hash_valid_i && cut;
         // job_end_o goes out with the last record, done_o a cycle later
         job_end_o <= hash_valid_i && hash_i.last;
         done_o    <= job_end_o;
         if (job_start_i) begin
            cnt_q <= '0;
         end else if (hash_valid_i) begin
            // Hash keeps rolling across cuts, only the length restarts
            cnt_q <= cut ? '0 : cnt_next;
         end
      end
   end

   // Record payload
   always_ff @(posedge wb_clk_i) begin
      if (hash_valid_i && cut) begin
         dst_data_o.hash <= hash_i.hash;
         dst_data_o.len  <= cnt_next;
         dst_data_o.last <= hash_i.last;
      end
   end

   // A byte arriving with a full chunk behind it means a missed forced cut
   a_len_bounded: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i)
      hash_valid_i |-> (cnt_q < MAX_LEN)
   );

endmodule

// ==== rb_config.svh ====
// Build-time limits of the chunking engine, shared by RTL and testbench
// RB_MAGIC must fit in RB_MAGIC_BITS and must not be zero,
// otherwise a run of zero bytes cuts at the minimum length
`ifndef RB_CONFIG_SVH
`define RB_CONFIG_SVH

// Rolling hash window in bytes
`define RB_WINDOW 16
// Odd multiplier of the rolling hash
`define RB_BASE 64'h0000_0100_0000_01B3

// Chunk length limits in bytes
`define RB_MIN_CHUNK 64
`define RB_MAX_CHUNK 512

// Content-defined cut on the low hash bits
`define RB_MAGIC_BITS 6
`define RB_MAGIC 6'h2A

`define RB_LEN_W 20

`endif

// ==== rb_pkg.sv ====
// Stream, hash and record types of the chunking engine
// Record length width follows RB_LEN_W from the config header
`include "rb_config.svh"

package rb_pkg;

   // One stream byte, last marks the final byte of the job
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } rb_byte_t;

   // Rolling hash after one byte
   typedef struct packed {
      logic [63:0] hash;
      logic        last;
   } rb_hash_t;

   // Chunk record written to the destination FIFO
   typedef struct packed {
      logic [63:0]           hash;
      logic [`RB_LEN_W-1:0]  len;
      logic                  last;
   } rb_record_t;

   // Byte feeder FSM
   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      SHIFT,
      DONE
   } rb_feed_state_e;

endpackage

// ==== rb_rabin.sv ====
// Rolling multiplicative hash over the last RB_WINDOW bytes, modulo 2^64
// Window and hash restart from zero on job_start_i
`timescale 1ns/1ps
`include "rb_config.svh"

module rb_rabin (
   input  logic             wb_clk_i,
   input  logic             wb_rst_i,
   input  logic             job_start_i,
   input  logic             byte_valid_i,
   input  rb_pkg::rb_byte_t byte_i,
   output logic             hash_valid_o,
   output rb_pkg::rb_hash_t hash_o
);

   localparam int unsigned WIN  = `RB_WINDOW;
   localparam logic [63:0] BASE = `RB_BASE;

   // BASE to the power n, wrapping at 64 bits
   function automatic logic [63:0] base_pow(input int unsigned n);
      logic [63:0] acc;
      acc = 64'd1;
      for (int unsigned i = 0; i < n; i++) begin
         acc = acc * BASE;
      end
      return acc;
   endfunction

   // Weight of the byte that leaves the window
   localparam logic [63:0] BASE_POW = base_pow(WIN);

   // Newest byte at index 0, oldest at WIN-1
   logic [WIN-1:0][7:0] window_q;
   logic [63:0]         byte_ext;
   logic [63:0]         drop_ext;
   logic [63:0]         hash_next;

   assign byte_ext = {56'd0, byte_i.data};
   assign drop_ext = {56'd0, window_q[WIN-1]};

   // h' = h*B + in - out*B^W
   assign hash_next = hash_o.hash * BASE + byte_ext - drop_ext * BASE_POW;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         hash_valid_o <= 1'b0;
      end else begin
         hash_valid_o <= byte_valid_i;
      end
   end

   // hash_o.hash doubles as the running hash
   always_ff @(posedge wb_clk_i) begin
      if (job_start_i) begin
         window_q    <= '0;
         hash_o.hash <= 64'd0;
         hash_o.last <= 1'b0;
      end else if (byte_valid_i) begin
         window_q    <= {window_q[WIN-2:0], byte_i.data};
         hash_o.hash <= hash_next;
         hash_o.last <= byte_i.last;
      end
   end

endmodule

// ==== rb_tb.sv ====
// Testbench for the chunking engine with queue models of both FIFOs and a reference model
// Source gaps come from a slow producer, destination stalls from a slow consumer
`timescale 1ns/1ps
`include "rb_config.svh"

module rb_tb;

   localparam int DST_DEPTH  = 4;
   localparam int WAIT_LIMIT = 100000;

   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } src_word_t;

   logic               wb_clk;
   logic               wb_rst;
   logic               start = 1'b0;
   logic [63:0]        src_data = 64'd0;
   logic               src_last = 1'b0;
   logic               src_empty = 1'b1;
   logic               src_get;
   logic               dst_almost_full = 1'b0;
   logic               dst_put;
   rb_pkg::rb_record_t dst_data;
   logic               busy;
   logic               done;

   src_word_t          job_words[$];
   src_word_t          pend_q[$];
   src_word_t          src_q[$];
   rb_pkg::rb_record_t dst_q[$];
   rb_pkg::rb_record_t rcv_q[$];
   rb_pkg::rb_record_t exp_q[$];
   bit                 gaps_on = 1'b0;
   bit                 stalls_on = 1'b0;
   bit                 last_put_q = 1'b0;
   bit                 timed_out = 1'b0;
   int                 done_cnt = 0;
   int                 err_cnt = 0;
   int                 test_cnt = 0;
   int                 fail_cnt = 0;

   tb_clock u_clock (
      .clk_o (wb_clk),
      .rst_o (wb_rst)
   );

   rb_top rb_top_inst (
      .wb_clk_i          (wb_clk),
      .wb_rst_i          (wb_rst),
      .start_i           (start),
      .src_data_i        (src_data),
      .src_last_i        (src_last),
      .src_empty_i       (src_empty),
      .src_get_o         (src_get),
      .dst_almost_full_i (dst_almost_full),
      .dst_put_o         (dst_put),
      .dst_data_o        (dst_data),
      .busy_o            (busy),
      .done_o            (done)
   );

   task automatic check_record(input int idx, input rb_pkg::rb_record_t exp,
                               input rb_pkg::rb_record_t got);
      if (got.hash !== exp.hash) begin
         $display("mismatch at %0t: dst_data_o.hash of record %0d expected %h got %h",
                  $time, idx, exp.hash, got.hash);
         err_cnt++;
      end
      if (got.len !== exp.len) begin
         $display("mismatch at %0t: dst_data_o.len of record %0d expected %0d got %0d",
                  $time, idx, exp.len, got.len);
         err_cnt++;
      end
      if (got.last !== exp.last) begin
         $display("mismatch at %0t: dst_data_o.last of record %0d expected %0b got %0b",
                  $time, idx, exp.last, got.last);
         err_cnt++;
      end
   endtask

   task automatic check_done(input string sig, input bit exp, input bit got);
      if (got !== exp) begin
         $display("mismatch at %0t: %s expected %0b got %0b", $time, sig, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_count(input string what, input int exp, input int got);
      if (got != exp) begin
         $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
         err_cnt++;
      end
   endtask

   task automatic report_timeout(input string name, input string why);
      $display("test %0d (%s): timed out at %0t, %s", test_cnt, name, $time, why);
      timed_out = 1'b1;
      err_cnt++;
      fail_cnt++;
   endtask

   task automatic make_words(input int n_words, input bit zeros);
      src_word_t w;
      job_words.delete();
      for (int i = 0; i < n_words; i++) begin
         w.data = zeros ? 64'd0 : {$urandom(), $urandom()};
         w.last = (i == n_words - 1);
         job_words.push_back(w);
      end
   endtask

   // Expected records of job_words with window and length starting from zero
   task automatic build_model();
      logic [7:0]         win[`RB_WINDOW];
      logic [63:0]        pw[`RB_WINDOW];
      logic [63:0]        h;
      logic [7:0]         b;
      bit                 last;
      int                 cnt;
      rb_pkg::rb_record_t rec;
      // Weight of the byte of age i is B^i
      pw[0] = 64'd1;
      for (int i = 1; i < `RB_WINDOW; i++) begin
         pw[i] = pw[i-1] * `RB_BASE;
      end
      for (int i = 0; i < `RB_WINDOW; i++) begin
         win[i] = 8'd0;
      end
      cnt = 0;
      exp_q.delete();
      foreach (job_words[w]) begin
         for (int k = 0; k < 8; k++) begin
            b    = job_words[w].data[8*k +: 8];
            last = job_words[w].last && (k == 7);
            for (int i = `RB_WINDOW - 1; i > 0; i--) begin
               win[i] = win[i-1];
            end
            win[0] = b;
            // Hash as a plain weighted sum over the window
            h = 64'd0;
            for (int i = 0; i < `RB_WINDOW; i++) begin
               h = h + {56'd0, win[i]} * pw[i];
            end
            cnt++;
            if (cnt == `RB_MAX_CHUNK || last ||
                (cnt >= `RB_MIN_CHUNK && h[`RB_MAGIC_BITS-1:0] == `RB_MAGIC)) begin
               rec.hash = h;
               rec.len  = cnt[`RB_LEN_W-1:0];
               rec.last = last;
               exp_q.push_back(rec);
               cnt = 0;
            end
         end
      end
   endtask

   task automatic run_job(input string name, input int n_words, input bit zeros,
                          input bit gaps, input bit stalls, input bit reuse);
      int                 errs_before;
      int                 done_before;
      int                 cycles;
      int                 len_sum;
      int                 tail;
      rb_pkg::rb_record_t rule_rec;
      test_cnt++;
      if (timed_out) begin
         $display("test %0d (%s): skipped after an earlier timeout", test_cnt, name);
         fail_cnt++;
         return;
      end
      errs_before = err_cnt;
      if (!reuse) begin
         make_words(n_words, zeros);
      end
      build_model();
      rcv_q.delete();
      gaps_on   = gaps;
      stalls_on = stalls;
      foreach (job_words[i]) begin
         pend_q.push_back(job_words[i]);
      end
      done_before = done_cnt;
      @(posedge wb_clk);
      start <= 1'b1;
      cycles = 0;
      while (!busy && cycles < 20) begin
         @(posedge wb_clk);
         cycles++;
      end
      start <= 1'b0;
      if (!busy) begin
         report_timeout(name, "busy_o did not rise after start_i");
         return;
      end
      cycles = 0;
      while (done_cnt == done_before && cycles < WAIT_LIMIT) begin
         @(posedge wb_clk);
         cycles++;
      end
      if (done_cnt == done_before) begin
         report_timeout(name, "done_o never pulsed");
         return;
      end
      cycles = 0;
      while (dst_q.size() != 0 && cycles < WAIT_LIMIT) begin
         @(posedge wb_clk);
         cycles++;
      end
      if (dst_q.size() != 0) begin
         report_timeout(name, "destination FIFO model never drained");
         return;
      end
      // Room for a stray second done pulse to show up
      repeat (2) @(posedge wb_clk);
      check_count("record count", exp_q.size(), rcv_q.size());
      for (int i = 0; i < exp_q.size() && i < rcv_q.size(); i++) begin
         check_record(i, exp_q[i], rcv_q[i]);
      end
      // Zero bytes keep the hash at zero, so only forced cuts and the tail remain
      if (zeros) begin
         tail = (n_words * 8) % `RB_MAX_CHUNK;
         foreach (rcv_q[i]) begin
            rule_rec.hash = 64'd0;
            rule_rec.last = (i == rcv_q.size() - 1);
            rule_rec.len  = `RB_MAX_CHUNK;
            if (rule_rec.last && tail != 0) begin
               rule_rec.len = tail[`RB_LEN_W-1:0];
            end
            check_record(i, rule_rec, rcv_q[i]);
         end
      end
      len_sum = 0;
      foreach (rcv_q[i]) begin
         len_sum += int'(rcv_q[i].len);
      end
      check_count("sum of dst_data_o.len", n_words * 8, len_sum);
      check_count("done_o pulses", 1, done_cnt - done_before);
      check_done("busy_o", 1'b0, busy);
      if (err_cnt == errs_before) begin
         $display("test %0d (%s): ok, %0d records", test_cnt, name, rcv_q.size());
      end else begin
         $display("test %0d (%s): FAILED with %0d errors", test_cnt, name,
                  err_cnt - errs_before);
         fail_cnt++;
      end
   endtask

   // Show-ahead source FIFO fed by a producer that may lag behind
   always @(posedge wb_clk) begin
      if (src_get) begin
         if (src_q.size() == 0) begin
            $display("Pop strobe at %0t while the source FIFO model is empty", $time);
            err_cnt++;
         end else begin
            void'(src_q.pop_front());
         end
      end
      if (gaps_on) begin
         if (pend_q.size() != 0 && $urandom_range(11) == 0) begin
            src_q.push_back(pend_q.pop_front());
         end
      end else begin
         while (pend_q.size() != 0) begin
            src_q.push_back(pend_q.pop_front());
         end
      end
      if (src_q.size() != 0) begin
         src_data  <= src_q[0].data;
         src_last  <= src_q[0].last;
         src_empty <= 1'b0;
      end else begin
         src_empty <= 1'b1;
      end
   end

   // Destination FIFO with a consumer that drains slowly during stalls
   always @(posedge wb_clk) begin
      if (dst_q.size() != 0 && (!stalls_on || $urandom_range(31) == 0)) begin
         rcv_q.push_back(dst_q.pop_front());
      end
      if (dst_put) begin
         if (dst_q.size() >= DST_DEPTH) begin
            $display("Record written at %0t while the destination FIFO was full", $time);
            err_cnt++;
         end else begin
            dst_q.push_back(dst_data);
         end
      end
      dst_almost_full <= (DST_DEPTH - dst_q.size()) < 3;
   end

   // done_o must follow the last record by one cycle
   always @(posedge wb_clk) begin
      if (!wb_rst) begin
         if (done || last_put_q) begin
            check_done("done_o", last_put_q, done);
         end
         if (done) begin
            done_cnt++;
            check_done("busy_o", 1'b0, busy);
         end
         last_put_q = dst_put && dst_data.last;
      end
   end

   initial begin
      int cycles;
      void'($urandom(14670));
      @(posedge wb_clk);
      cycles = 0;
      while (wb_rst && cycles < 20) begin
         @(posedge wb_clk);
         cycles++;
      end
      if (wb_rst) begin
         $display("Reset was never released");
         timed_out = 1'b1;
         err_cnt++;
      end
      run_job("20 random words", 20, 1'b0, 1'b0, 1'b0, 1'b0);
      run_job("150 zero words", 150, 1'b1, 1'b0, 1'b0, 1'b0);
      run_job("80 words with gaps and stalls", 80, 1'b0, 1'b1, 1'b1, 1'b0);
      // A job shorter than the window ends while old bytes would still be in it
      run_job("1 random word", 1, 1'b0, 1'b0, 1'b0, 1'b0);
      run_job("same word again", 1, 1'b0, 1'b0, 1'b0, 1'b1);
      $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== rb_top.sv ====
// Content-defined chunking engine: byte feeder, rolling hash, chunker
// Destination FIFO needs 3 free slots whenever almost-full is low
`timescale 1ns/1ps

module rb_top (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  logic               start_i,
   input  logic [63:0]        src_data_i,
   input  logic               src_last_i,
   input  logic               src_empty_i,
   output logic               src_get_o,
   input  logic               dst_almost_full_i,
   output logic               dst_put_o,
   output rb_pkg::rb_record_t dst_data_o,
   output logic               busy_o,
   output logic               done_o
);

   logic             byte_valid;
   rb_pkg::rb_byte_t byte_s;
   logic             hash_valid;
   rb_pkg::rb_hash_t hash_s;
   logic             job_start;
   logic             job_end;

   rb_byte_feeder u_feeder (
      .wb_clk_i          (wb_clk_i),
      .wb_rst_i          (wb_rst_i),
      .start_i           (start_i),
      .src_data_i        (src_data_i),
      .src_last_i        (src_last_i),
      .src_empty_i       (src_empty_i),
      .dst_almost_full_i (dst_almost_full_i),
      .job_end_i         (job_end),
      .src_get_o         (src_get_o),
      .byte_valid_o      (byte_valid),
      .byte_o            (byte_s),
      .job_start_o       (job_start),
      .busy_o            (busy_o)
   );

   rb_rabin u_rabin (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .job_start_i  (job_start),
      .byte_valid_i (byte_valid),
      .byte_i       (byte_s),
      .hash_valid_o (hash_valid),
      .hash_o       (hash_s)
   );

   rb_chunker u_chunker (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .job_start_i  (job_start),
      .hash_valid_i (hash_valid),
      .hash_i       (hash_s),
      .dst_put_o    (dst_put_o),
      .dst_data_o   (dst_data_o),
      .job_end_o    (job_end),
      .done_o       (done_o)
   );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the chunking engine testbench with Verilator, runs it and looks for the pass line
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module rb_tb -o rb_sim \
   && ./obj_dir/rb_sim | tee /dev/stderr | grep -qx "Testbench passed" \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

// ==== tb_clock.sv ====
// Testbench clock with a 100 ns period
// Reset is high from time zero until the third rising edge
`timescale 1ns/1ps

module tb_clock (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #50 clk_o = ~clk_o;
      end
   end

   initial begin
      rst_o = 1'b1;
      repeat (3) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule
